/* Bender.yml */
package:
  name: simd_alu

sources:
  - files:
      - logic/simd_cfg_pkg.sv
      - logic/alu_op_pkg.sv
      - logic/add_sub.sv
      - logic/alu_lane.sv
      - logic/operand_dispatch.sv
      - logic/result_collect.sv
      - logic/simd_alu_top.sv
  - target: test
    files:
      - tb/clk_gen.sv
      - tb/simd_alu_tb.sv

/* logic/add_sub.sv */
`timescale 1ns/1ps

module add_sub #(
    parameter int BW = 8
) (
    input  logic          sub,
    input  logic [BW-1:0] a,
    input  logic [BW-1:0] b,
    output logic [BW-1:0] sum,
    output logic          ovf
);

    logic [BW-1:0] b_eff;

    // subtract as a + ~b + 1
    assign b_eff = b ^ {BW{sub}};
    assign sum   = a + b_eff + {{(BW-1){1'b0}}, sub};

    // same input signs, different result sign
    assign ovf = (a[BW-1] == b_eff[BW-1]) && (sum[BW-1] != a[BW-1]);

endmodule

/* logic/alu_lane.sv */
`timescale 1ns/1ps

module alu_lane #(
    parameter int BW = simd_cfg_pkg::BW_DEF
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               valid,
    input  alu_op_pkg::op_t    op,
    input  logic               is_unsigned,
    input  logic [BW-1:0]      a,
    input  logic [BW-1:0]      b,
    output logic [BW-1:0]      res,
    output logic               ovf,
    output logic               done
);

    import alu_op_pkg::*;

    localparam int SH_W = $clog2(BW);

    logic              as_sub;
    logic [BW-1:0]     as_a;
    logic [BW-1:0]     as_b;
    logic [BW-1:0]     as_sum;
    logic              as_ovf;

    logic              lt_bit;
    logic [SH_W-1:0]   sh_amt;
    logic              sh_big;

    logic [BW-1:0]     res_c;
    logic              ovf_c;

    // shared adder, neg runs as 0 - a
    assign as_sub = (op != OP_ADD);
    assign as_a   = (op == OP_NEG) ? '0 : a;
    assign as_b   = (op == OP_NEG) ? a : b;

    add_sub #(
        .BW  (BW)
    ) u_add_sub (
        .sub (as_sub),
        .a   (as_a),
        .b   (as_b),
        .sum (as_sum),
        .ovf (as_ovf)
    );

    always_comb begin
        if (is_unsigned) begin
            lt_bit = (a < b);
        end else if (a[BW-1] != b[BW-1]) begin
            lt_bit = a[BW-1];                   // negative side is smaller
        end else begin
            lt_bit = as_sum[BW-1];              // same sign, look at a - b
        end
    end

    // upper bits of b set means the amount is BW or more
    assign sh_amt = b[SH_W-1:0];
    assign sh_big = |b[BW-1:SH_W];

    always_comb begin
        res_c = '0;
        ovf_c = 1'b0;
        case (op)
            OP_ADD,
            OP_SUB: begin
                res_c = as_sum;
                ovf_c = as_ovf;
            end
            OP_NEG: res_c = as_sum;
            OP_AND: res_c = a & b;
            OP_OR:  res_c = a | b;
            OP_XOR: res_c = a ^ b;
            OP_LT:  res_c = {{(BW-1){1'b0}}, lt_bit};
            OP_EQ:  res_c = {{(BW-1){1'b0}}, (a == b)};
            OP_SLL: begin
                if (!sh_big) begin
                    res_c = a << sh_amt;
                end
            end
            OP_SRL: begin
                if (!sh_big) begin
                    res_c = a >> sh_amt;
                end
            end
            OP_SRA: begin
                if (sh_big) begin
                    res_c = {BW{a[BW-1]}};      // all sign bits
                end else begin
                    res_c = $signed(a) >>> sh_amt;
                end
            end
            default: begin
                res_c = '0;
                ovf_c = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            done <= 1'b0;
        end else begin
            done <= valid;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            res <= res_c;
            ovf <= ovf_c;
        end
    end

endmodule

/* logic/alu_op_pkg.sv */
package alu_op_pkg;

    localparam int OP_W = 4;

    typedef logic [OP_W-1:0] op_t;

    // arithmetic
    localparam op_t OP_ADD = 4'd0;  // a + b, signed ovf
    localparam op_t OP_SUB = 4'd1;  // a - b, signed ovf
    localparam op_t OP_NEG = 4'd2;  // 0 - a

    // bitwise
    localparam op_t OP_AND = 4'd3;
    localparam op_t OP_OR  = 4'd4;
    localparam op_t OP_XOR = 4'd5;

    // compares give 0 or 1 in bit 0
    localparam op_t OP_LT  = 4'd6;  // signedness from cmp flag
    localparam op_t OP_EQ  = 4'd7;  // 1 when operands match

    // shifts take the amount from b
    localparam op_t OP_SLL = 4'd8;
    localparam op_t OP_SRL = 4'd9;
    localparam op_t OP_SRA = 4'd10; // sign fill

    // 11..15 unused, lane returns zero

endpackage

/* logic/operand_dispatch.sv */
`timescale 1ns/1ps

module operand_dispatch #(
    parameter int BW    = simd_cfg_pkg::BW_DEF,
    parameter int LANES = simd_cfg_pkg::LANES_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  alu_op_pkg::op_t       op,
    input  logic                  cmp_unsigned,
    input  logic                  bcast,
    input  logic [LANES*BW-1:0]   d1,
    input  logic [LANES*BW-1:0]   d2,
    output logic                  lane_valid,
    output alu_op_pkg::op_t       lane_op,
    output logic                  lane_unsigned,
    output logic [LANES*BW-1:0]   lane_d1,
    output logic [LANES*BW-1:0]   lane_d2
);

    import alu_op_pkg::*;

    op_t                  op_q;
    logic [LANES*BW-1:0]  d2_sel;

    // scalar broadcast of d2 lane 0
    for (genvar i = 0; i < LANES; i++) begin : g_bcast
        assign d2_sel[i*BW +: BW] = bcast ? d2[BW-1:0] : d2[i*BW +: BW];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            lane_valid <= 1'b0;
        end else begin
            lane_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            op_q          <= op;
            lane_unsigned <= cmp_unsigned;
            lane_d1       <= d1;
            lane_d2       <= d2_sel;
        end
    end

    assign lane_op = op_q;                  // one op shared by all lanes

endmodule

/* logic/result_collect.sv */
`timescale 1ns/1ps

module result_collect #(
    parameter int BW    = simd_cfg_pkg::BW_DEF,
    parameter int LANES = simd_cfg_pkg::LANES_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [LANES-1:0]      lane_done,
    input  logic [LANES*BW-1:0]   lane_res,
    input  logic [LANES-1:0]      lane_ovf,
    input  logic                  ovf_clr,
    output logic                  out_valid,
    output logic [LANES*BW-1:0]   res,
    output logic [LANES-1:0]      ovf,
    output logic                  ovf_sticky
);

    logic strobe;
    logic sticky_set;

    // lanes run in lockstep, lane 0 speaks for all
    assign strobe = lane_done[0];

    // flag from the result now on the outputs
    assign sticky_set = out_valid && (|ovf);

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            res       <= '0;
            ovf       <= '0;
        end else begin
            out_valid <= strobe;
            if (strobe) begin
                res <= lane_res;
                ovf <= lane_ovf;                // hold last value otherwise
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ovf_sticky <= 1'b0;
        end else if (sticky_set) begin
            ovf_sticky <= 1'b1;                 // set beats clear
        end else if (ovf_clr) begin
            ovf_sticky <= 1'b0;
        end
    end

endmodule

/* logic/simd_alu_top.sv */
`timescale 1ns/1ps

module simd_alu_top #(
    parameter int BW    = simd_cfg_pkg::BW_DEF,
    parameter int LANES = simd_cfg_pkg::LANES_DEF
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  alu_op_pkg::op_t       op,
    input  logic                  cmp_unsigned,
    input  logic                  bcast,
    input  logic [LANES*BW-1:0]   d1,
    input  logic [LANES*BW-1:0]   d2,
    input  logic                  ovf_clr,
    output logic                  out_valid,
    output logic [LANES*BW-1:0]   res,
    output logic [LANES-1:0]      ovf,
    output logic                  ovf_sticky
);

    import alu_op_pkg::*;

    logic                 lane_valid;
    op_t                  lane_op;
    logic                 lane_unsigned;
    logic [LANES*BW-1:0]  lane_d1;
    logic [LANES*BW-1:0]  lane_d2;

    logic [LANES*BW-1:0]  lane_res;
    logic [LANES-1:0]     lane_ovf;
    logic [LANES-1:0]     lane_done;

    operand_dispatch #(
        .BW            (BW),
        .LANES         (LANES)
    ) u_dispatch (
        .clk           (clk),
        .rst           (rst),
        .in_valid      (in_valid),
        .op            (op),
        .cmp_unsigned  (cmp_unsigned),
        .bcast         (bcast),
        .d1            (d1),
        .d2            (d2),
        .lane_valid    (lane_valid),
        .lane_op       (lane_op),
        .lane_unsigned (lane_unsigned),
        .lane_d1       (lane_d1),
        .lane_d2       (lane_d2)
    );

    for (genvar i = 0; i < LANES; i++) begin : g_lane
        alu_lane #(
            .BW          (BW)
        ) u_lane (
            .clk         (clk),
            .rst         (rst),
            .valid       (lane_valid),
            .op          (lane_op),
            .is_unsigned (lane_unsigned),
            .a           (lane_d1[i*BW +: BW]),
            .b           (lane_d2[i*BW +: BW]),
            .res         (lane_res[i*BW +: BW]),
            .ovf         (lane_ovf[i]),
            .done        (lane_done[i])
        );
    end

    result_collect #(
        .BW         (BW),
        .LANES      (LANES)
    ) u_collect (
        .clk        (clk),
        .rst        (rst),
        .lane_done  (lane_done),
        .lane_res   (lane_res),
        .lane_ovf   (lane_ovf),
        .ovf_clr    (ovf_clr),
        .out_valid  (out_valid),
        .res        (res),
        .ovf        (ovf),
        .ovf_sticky (ovf_sticky)
    );

endmodule

/* logic/simd_cfg_pkg.sv */
package simd_cfg_pkg;

    // default vector shape, overridden at simd_alu_top
    localparam int LANES_DEF = 4; // lanes per vector
    localparam int BW_DEF    = 8; // bits per lane, power of two

endpackage

/* simd_alu_top.f */
logic/simd_cfg_pkg.sv
logic/alu_op_pkg.sv
logic/add_sub.sv
logic/alu_lane.sv
logic/operand_dispatch.sv
logic/result_collect.sv
logic/simd_alu_top.sv
tb/clk_gen.sv
tb/simd_alu_tb.sv

/* tb/clk_gen.sv */
`timescale 1ns/1ps

module clk_gen #(
    parameter int PERIOD = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD/2) clk = ~clk;     // first rising edge at PERIOD/2
    end

endmodule

/* tb/simd_alu_tb.sv */
`timescale 1ns/1ps

module simd_alu_tb;

    import alu_op_pkg::*;

    localparam int BW     = 8;
    localparam int LANES  = 4;
    localparam int VW     = LANES*BW;
    localparam int N_RAND = 200;
    localparam int SMAX   = 2**(BW-1) - 1;
    localparam int SMIN   = -(2**(BW-1));

    logic             clk;
    logic             rst;
    logic             in_valid;
    op_t              op;
    logic             cmp_unsigned;
    logic             bcast;
    logic [VW-1:0]    d1;
    logic [VW-1:0]    d2;
    logic             ovf_clr;
    logic             out_valid;
    logic [VW-1:0]    res;
    logic [LANES-1:0] ovf;
    logic             ovf_sticky;

    string            row_name[$];
    op_t              row_op[$];
    logic             row_cu[$];
    logic             row_bc[$];
    logic [VW-1:0]    row_d1[$];
    logic [VW-1:0]    row_d2[$];
    logic             row_clr[$];

    string            exp_name_q[$];          // expected results, issue order
    logic [VW-1:0]    exp_res_q[$];
    logic [LANES-1:0] exp_ovf_q[$];
    int               iss_q[$];               // cycle each input was presented

    int               cyc = 0;
    int               limit = 1000000;
    logic             exp_sticky = 1'b0;
    string            last_name = "reset";

    clk_gen #(.PERIOD(100)) u_clk (.clk(clk));

    simd_alu_top #(
        .BW           (BW),
        .LANES        (LANES)
    ) UUT (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (in_valid),
        .op           (op),
        .cmp_unsigned (cmp_unsigned),
        .bcast        (bcast),
        .d1           (d1),
        .d2           (d2),
        .ovf_clr      (ovf_clr),
        .out_valid    (out_valid),
        .res          (res),
        .ovf          (ovf),
        .ovf_sticky   (ovf_sticky)
    );

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_res(input string name, input logic [VW-1:0] exp,
                             input logic [VW-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Error: %s res expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_ovf(input string name, input logic [LANES-1:0] exp,
                             input logic [LANES-1:0] act);
        if (act !== exp) begin
            stop_run($sformatf("Error: %s ovf expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic check_sticky(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("Error: %s ovf_sticky expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic add_row(input string name, input op_t o, input logic cu, input logic bc,
                           input logic [VW-1:0] a, input logic [VW-1:0] b, input logic clr);
        row_name.push_back(name);
        row_op.push_back(o);
        row_cu.push_back(cu);
        row_bc.push_back(bc);
        row_d1.push_back(a);
        row_d2.push_back(b);
        row_clr.push_back(clr);
    endtask

    // per-lane results computed in plain integer arithmetic
    task automatic ref_model(input op_t o, input logic cu, input logic bc,
                             input logic [VW-1:0] va, input logic [VW-1:0] vb,
                             output logic [VW-1:0] r, output logic [LANES-1:0] f);
        int            sa;
        int            sb;
        int            ua;
        int            ub;
        int            s;
        logic [BW-1:0] a;
        logic [BW-1:0] b;
        logic [BW-1:0] lr;
        logic          lo;
        r = '0;
        f = '0;
        for (int i = 0; i < LANES; i++) begin
            a  = va[i*BW +: BW];
            b  = bc ? vb[BW-1:0] : vb[i*BW +: BW];
            sa = $signed(a);
            sb = $signed(b);
            ua = a;
            ub = b;
            lr = '0;
            lo = 1'b0;
            case (o)
                OP_ADD: begin
                    s  = sa + sb;
                    lr = s[BW-1:0];
                    lo = (s > SMAX) || (s < SMIN);
                end
                OP_SUB: begin
                    s  = sa - sb;
                    lr = s[BW-1:0];
                    lo = (s > SMAX) || (s < SMIN);
                end
                OP_NEG: begin
                    s  = -sa;
                    lr = s[BW-1:0];
                end
                OP_AND: lr = a & b;
                OP_OR:  lr = a | b;
                OP_XOR: lr = a ^ b;
                OP_LT:  lr = cu ? (ua < ub) : (sa < sb);
                OP_EQ:  lr = (a == b);
                OP_SLL: begin
                    s  = ua << ub;
                    lr = (ub >= BW) ? '0 : s[BW-1:0];
                end
                OP_SRL: lr = (ub >= BW) ? '0 : ua >> ub;
                OP_SRA: begin
                    s  = sa >>> ((ub >= BW) ? BW : ub);   // int keeps the sign
                    lr = s[BW-1:0];
                end
                default: lr = '0;
            endcase
            r[i*BW +: BW] = lr;
            f[i]          = lo;
        end
    endtask

    task automatic build_table();
        add_row("add_edge",      OP_ADD, 0, 0, 32'h10ff_807f, 32'h2001_ff01, 0);
        add_row("sub_edge",      OP_SUB, 0, 0, 32'h0500_7f80, 32'h0380_ff01, 0);
        add_row("add_clean",     OP_ADD, 0, 0, 32'h0102_0304, 32'h1020_3040, 0);
        add_row("neg",           OP_NEG, 0, 0, 32'h807f_0100, 32'hdead_beef, 0);
        add_row("and",           OP_AND, 0, 0, 32'hf0f0_aa55, 32'h0ff0_ff0f, 0);
        add_row("or",            OP_OR,  0, 0, 32'hf0f0_aa55, 32'h0ff0_ff0f, 0);
        add_row("xor",           OP_XOR, 0, 0, 32'hf0f0_aa55, 32'h0ff0_ff0f, 0);
        add_row("undef_11",      op_t'(11), 0, 0, 32'hffff_ffff, 32'hffff_ffff, 0);
        add_row("undef_15_clr",  op_t'(15), 0, 0, 32'h7f7f_7f7f, 32'h0101_0101, 1);
        add_row("lt_signed",     OP_LT,  0, 0, 32'h7f01_80ff, 32'h80ff_0100, 0);
        add_row("lt_unsigned",   OP_LT,  1, 0, 32'h7f01_80ff, 32'h80ff_0100, 0);
        add_row("eq",            OP_EQ,  0, 0, 32'h1234_5678, 32'h1200_5679, 0);
        add_row("sll_amts",      OP_SLL, 0, 0, 32'h8181_8181, 32'h0807_0300, 0);
        add_row("sll_200",       OP_SLL, 0, 0, 32'hffff_ffff, 32'hc8c8_c8c8, 0);
        add_row("srl_amts",      OP_SRL, 0, 0, 32'h8181_8181, 32'h0807_0300, 0);
        add_row("srl_200",       OP_SRL, 0, 0, 32'hffff_ffff, 32'hc8c8_c8c8, 0);
        add_row("sra_amts",      OP_SRA, 0, 0, 32'h8181_8181, 32'h0807_0300, 0);
        add_row("sra_200",       OP_SRA, 0, 0, 32'h40c0_817f, 32'hc8c8_c8c8, 0);
        add_row("sra_pos",       OP_SRA, 0, 0, 32'h7f7f_7f7f, 32'h0807_0300, 0);
        add_row("sticky_ovf",    OP_ADD, 0, 0, 32'h0000_007f, 32'h0000_0001, 0);
        add_row("sticky_hold_a", OP_AND, 0, 0, 32'h1111_1111, 32'h0f0f_0f0f, 0);
        add_row("sticky_hold_b", OP_OR,  0, 0, 32'h1111_1111, 32'h0f0f_0f0f, 0);
        add_row("sticky_set_win", OP_XOR, 0, 0, 32'h2222_2222, 32'h0f0f_0f0f, 1); // clr meets sticky_ovf result
        add_row("sticky_hold_c", OP_XOR, 0, 0, 32'h1111_1111, 32'h0f0f_0f0f, 0);
        add_row("bcast_add",     OP_ADD, 0, 1, 32'h0102_0304, 32'haabb_cc10, 0);
        add_row("bcast_sra",     OP_SRA, 0, 1, 32'h80f0_817f, 32'hc8c8_c803, 0);
        add_row("sticky_clear",  OP_AND, 0, 0, 32'h3333_3333, 32'h0f0f_0f0f, 1);
    endtask

    task automatic add_random_rows(input int n);
        op_t           o;
        logic [VW-1:0] b;
        for (int i = 0; i < n; i++) begin
            o = op_t'($urandom % 16);
            b = $urandom;
            if (o >= OP_SLL && o <= OP_SRA && ($urandom % 2) == 1) begin
                b = b & 32'h0707_0f0f;          // some amounts below BW
            end
            add_row($sformatf("rand_%0d", i), o, $urandom % 2, $urandom % 2, $urandom, b,
                    ($urandom % 8) == 0);
        end
    endtask

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= limit) begin
            stop_run($sformatf("timeout: run did not finish within %0d cycles", limit));
        end
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin : monitor
        logic             set_now;
        logic [VW-1:0]    e_res;
        logic [LANES-1:0] e_ovf;
        set_now = 1'b0;
        if (rst) begin
            exp_sticky = 1'b0;
        end else begin
            check_sticky(last_name, exp_sticky, ovf_sticky);
            if (out_valid === 1'b1) begin
                if (exp_res_q.size() == 0 || iss_q.size() == 0) begin
                    stop_run("out_valid came while no result was expected");
                end else if (cyc - iss_q[0] != 3) begin
                    stop_run($sformatf("result for %s came %0d cycles after its input, not 3",
                                       exp_name_q[0], cyc - iss_q[0]));
                end else begin
                    last_name = exp_name_q.pop_front();
                    e_res     = exp_res_q.pop_front();
                    e_ovf     = exp_ovf_q.pop_front();
                    void'(iss_q.pop_front());
                    check_res(last_name, e_res, res);
                    check_ovf(last_name, e_ovf, ovf);
                    set_now = |e_ovf;
                end
            end
            if (iss_q.size() > 0 && cyc > iss_q[0] + 3) begin
                stop_run($sformatf("no result for %s 3 cycles after its input", exp_name_q[0]));
            end else begin
                if (in_valid) begin
                    iss_q.push_back(cyc);       // in_valid high this cycle
                end
                if (set_now) begin
                    exp_sticky = 1'b1;          // set wins over clear
                end else if (ovf_clr) begin
                    exp_sticky = 1'b0;
                end
            end
        end
    end

    initial begin : driver
        logic [VW-1:0]    e_res;
        logic [LANES-1:0] e_ovf;
        void'($urandom(907));
        rst          = 1'b1;
        in_valid     = 1'b0;
        op           = OP_ADD;
        cmp_unsigned = 1'b0;
        bcast        = 1'b0;
        d1           = '0;
        d2           = '0;
        ovf_clr      = 1'b0;
        build_table();
        add_random_rows(N_RAND);
        limit = 10 + row_op.size() + 3 + 20;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < row_op.size(); n++) begin
            @(posedge clk);
            in_valid     <= 1'b1;
            op           <= row_op[n];
            cmp_unsigned <= row_cu[n];
            bcast        <= row_bc[n];
            d1           <= row_d1[n];
            d2           <= row_d2[n];
            ovf_clr      <= row_clr[n];
            ref_model(row_op[n], row_cu[n], row_bc[n], row_d1[n], row_d2[n], e_res, e_ovf);
            exp_name_q.push_back(row_name[n]);
            exp_res_q.push_back(e_res);
            exp_ovf_q.push_back(e_ovf);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        ovf_clr  <= 1'b0;
        while (exp_res_q.size() > 0) begin
            @(posedge clk);
        end
        repeat (2) @(negedge clk);              // last sticky update
        $display("TB PASSED");
        $finish;
    end

endmodule
